/* adc_core_pkg.sv */
package adc_core_pkg;

  // **************************************************
  // widths
  // **************************************************

  typedef logic [15:0] adc_sample_t;
  typedef logic [13:0] up_addr_t;
  typedef logic [31:0] up_data_t;

  // one captured converter word
  typedef struct packed {
    adc_sample_t sample;
    logic        over_range;
    logic        valid;
  } adc_word_t;

  // processor strobe bus, request side
  typedef struct packed {
    logic     wreq;
    up_addr_t waddr;
    up_data_t wdata;
    logic     rreq;
    up_addr_t raddr;
  } up_req_t;

  // response side, zero when the address is not ours
  typedef struct packed {
    logic     wack;
    logic     rack;
    up_data_t rdata;
  } up_resp_t;

  typedef enum logic {
    PN_OOS  = 1'b0,
    PN_SYNC = 1'b1
  } pn_state_t;

  localparam up_data_t CORE_VERSION = 32'h0001_0a61;
  localparam up_data_t CORE_ID      = 32'h0000_0010;

  // **************************************************
  // register map
  // **************************************************

  localparam up_addr_t ADDR_VERSION     = 14'h000;
  localparam up_addr_t ADDR_ID          = 14'h001;
  localparam up_addr_t ADDR_SCRATCH     = 14'h002;
  localparam up_addr_t ADDR_IF_STATUS   = 14'h003;
  localparam up_addr_t ADDR_RSTN        = 14'h010;
  localparam up_addr_t ADDR_CHAN_CNTRL  = 14'h100;
  localparam up_addr_t ADDR_CHAN_STATUS = 14'h101;

  // test pattern, x^16+x^14+x^13+x^11+1 -> bits 15,13,12,10
  localparam int          PN_LOCK_COUNT = 4;
  localparam int          PN_LOSS_COUNT = 4;
  localparam adc_sample_t PN_TAPS       = 16'hb400;

endpackage

/* adc_if.sv */
module adc_if
  import adc_core_pkg::*;
(
  input  logic        up_clk,
  input  logic        up_rstn,
  input  logic        adc_in_valid,
  input  adc_sample_t adc_data_in,
  input  logic        adc_or_in,
  output adc_word_t   adc_word,
  output logic        adc_status
);

  adc_sample_t sample_q;
  logic        or_q;
  logic        valid_q;

  // capture strobe
  always_ff @(posedge up_clk) begin
    if (!up_rstn) begin
      valid_q    <= 1'b0;
      adc_status <= 1'b0;
    end else begin
      valid_q <= adc_in_valid;
      // set on the first sample, held until reset
      if (adc_in_valid) begin
        adc_status <= 1'b1;
      end
    end
  end

  // sample payload
  always_ff @(posedge up_clk) begin
    if (adc_in_valid) begin
      sample_q <= adc_data_in;
      or_q     <= adc_or_in;
    end
  end

  assign adc_word = '{sample: sample_q, over_range: or_q, valid: valid_q};

  // back to back words need back to back input strobes
  a_valid_follows_input : assert property (@(posedge up_clk) disable iff (!up_rstn)
    (adc_word.valid && $past(adc_word.valid)) |-> ($past(adc_in_valid) && $past(adc_in_valid, 2)));

endmodule

/* adc_pn_mon.sv */
module adc_pn_mon
  import adc_core_pkg::*;
(
  input  logic      up_clk,
  input  logic      up_rstn,
  input  logic      adc_rst,
  input  adc_word_t adc_word,
  output logic      pn_oos,
  output logic      pn_err
);

  adc_sample_t pn_prev;
  adc_sample_t pn_expect;
  logic        word_in;
  logic        pn_match;
  logic [2:0]  pn_count;
  pn_state_t   pn_state;

  // shift left, feedback into bit 0
  function automatic adc_sample_t pn_next(input adc_sample_t d);
    return {d[14:0], ^(d & PN_TAPS)};
  endfunction

  // words captured while the data path is held are ignored
  assign word_in   = adc_word.valid & ~adc_rst;
  assign pn_expect = pn_next(pn_prev);
  assign pn_match  = (adc_word.sample == pn_expect);
  assign pn_oos    = (pn_state == PN_OOS);

  // **************************************************
  // sync state machine
  // **************************************************

  always_ff @(posedge up_clk) begin
    if (!up_rstn) begin
      pn_prev  <= '0;
      pn_state <= PN_OOS;
      pn_count <= '0;
      pn_err   <= 1'b0;
    end else begin
      pn_err <= 1'b0;
      if (word_in) begin
        // self seeding, the next check uses whatever arrived
        pn_prev <= adc_word.sample;
        case (pn_state)
          PN_OOS: begin
            if (!pn_match) begin
              pn_count <= '0;
            end else if (pn_count == 3'(PN_LOCK_COUNT - 1)) begin
              pn_state <= PN_SYNC;
              pn_count <= '0;
            end else begin
              pn_count <= pn_count + 3'd1;
            end
          end
          PN_SYNC: begin
            if (pn_match) begin
              pn_count <= '0;
            end else if (pn_count == 3'(PN_LOSS_COUNT - 1)) begin
              // losing sync, flagged by pn_oos instead of pn_err
              pn_state <= PN_OOS;
              pn_count <= '0;
            end else begin
              pn_count <= pn_count + 3'd1;
              pn_err   <= 1'b1;
            end
          end
          default: begin
            pn_state <= PN_OOS;
            pn_count <= '0;
          end
        endcase
      end
    end
  end

  a_err_only_in_sync : assert property (@(posedge up_clk) disable iff (!up_rstn)
    pn_err |-> !pn_oos);

endmodule

/* adc_channel.sv */
module adc_channel
  import adc_core_pkg::*;
(
  input  logic        up_clk,
  input  logic        up_rstn,
  input  logic        adc_rst,
  input  adc_word_t   adc_word,
  input  up_req_t     up_req,
  output up_resp_t    up_resp,
  output logic        adc_valid,
  output adc_sample_t adc_data,
  output logic        adc_enable
);

  logic chan_format;
  logic pn_oos;
  logic pn_err;
  logic err_sticky;
  logic or_sticky;
  logic wr_cntrl;
  logic wr_status;
  logic rd_cntrl;
  logic rd_status;

  adc_pn_mon i_pn_mon (
    .up_clk   (up_clk),
    .up_rstn  (up_rstn),
    .adc_rst  (adc_rst),
    .adc_word (adc_word),
    .pn_oos   (pn_oos),
    .pn_err   (pn_err)
  );

  assign wr_cntrl  = up_req.wreq && (up_req.waddr == ADDR_CHAN_CNTRL);
  assign wr_status = up_req.wreq && (up_req.waddr == ADDR_CHAN_STATUS);
  assign rd_cntrl  = up_req.rreq && (up_req.raddr == ADDR_CHAN_CNTRL);
  assign rd_status = up_req.rreq && (up_req.raddr == ADDR_CHAN_STATUS);

  // **************************************************
  // sample output
  // **************************************************

  always_ff @(posedge up_clk) begin
    if (!up_rstn) begin
      adc_valid <= 1'b0;
    end else begin
      adc_valid <= adc_word.valid & adc_enable & ~adc_rst;
    end
  end

  // format bit flips the msb, offset binary to two's complement
  always_ff @(posedge up_clk) begin
    if (adc_word.valid) begin
      adc_data <= chan_format ? {~adc_word.sample[15], adc_word.sample[14:0]}
                              : adc_word.sample;
    end
  end

  // **************************************************
  // registers and status
  // **************************************************

  always_ff @(posedge up_clk) begin
    if (!up_rstn) begin
      adc_enable  <= 1'b0;
      chan_format <= 1'b0;
      err_sticky  <= 1'b0;
      or_sticky   <= 1'b0;
      up_resp     <= '0;
    end else begin
      if (wr_cntrl) begin
        adc_enable  <= up_req.wdata[0];
        chan_format <= up_req.wdata[1];
      end
      // a new event wins over a clear in the same cycle
      if (pn_err) begin
        err_sticky <= 1'b1;
      end else if (wr_status && up_req.wdata[0]) begin
        err_sticky <= 1'b0;
      end
      if (adc_word.valid && adc_word.over_range) begin
        or_sticky <= 1'b1;
      end else if (wr_status && up_req.wdata[2]) begin
        or_sticky <= 1'b0;
      end
      up_resp.wack <= wr_cntrl | wr_status;
      up_resp.rack <= rd_cntrl | rd_status;
      if (rd_cntrl) begin
        up_resp.rdata <= {30'd0, chan_format, adc_enable};
      end else if (rd_status) begin
        up_resp.rdata <= {29'd0, or_sticky, pn_oos, err_sticky};
      end else begin
        up_resp.rdata <= '0;
      end
    end
  end

endmodule

/* adc_common.sv */
module adc_common
  import adc_core_pkg::*;
(
  input  logic     up_clk,
  input  logic     up_rstn,
  input  logic     adc_status,
  input  up_req_t  up_req,
  output up_resp_t up_resp,
  output logic     adc_rst
);

  up_data_t up_scratch;
  up_data_t rd_data;
  logic     rstn_release;
  logic     wr_hit;
  logic     rd_hit;

  // writes to the read-only words are acked and dropped
  assign wr_hit = up_req.wreq && (up_req.waddr inside {ADDR_VERSION, ADDR_ID,
                  ADDR_SCRATCH, ADDR_IF_STATUS, ADDR_RSTN});

  // read mux
  always_comb begin
    rd_hit  = 1'b1;
    rd_data = '0;
    case (up_req.raddr)
      ADDR_VERSION:   rd_data = CORE_VERSION;
      ADDR_ID:        rd_data = CORE_ID;
      ADDR_SCRATCH:   rd_data = up_scratch;
      ADDR_IF_STATUS: rd_data = {31'd0, adc_status};
      ADDR_RSTN:      rd_data = {31'd0, rstn_release};
      default:        rd_hit  = 1'b0;
    endcase
  end

  // **************************************************
  // registers
  // **************************************************

  always_ff @(posedge up_clk) begin
    if (!up_rstn) begin
      up_scratch   <= '0;
      rstn_release <= 1'b0;
      adc_rst      <= 1'b1;
      up_resp      <= '0;
    end else begin
      if (up_req.wreq && (up_req.waddr == ADDR_SCRATCH)) begin
        up_scratch <= up_req.wdata;
      end
      if (up_req.wreq && (up_req.waddr == ADDR_RSTN)) begin
        rstn_release <= up_req.wdata[0];
      end
      // data path held until software releases it
      adc_rst       <= ~rstn_release;
      up_resp.wack  <= wr_hit;
      up_resp.rack  <= up_req.rreq && rd_hit;
      up_resp.rdata <= (up_req.rreq && rd_hit) ? rd_data : '0;
    end
  end

  // one request in flight, so never both acks
  a_single_ack : assert property (@(posedge up_clk) disable iff (!up_rstn)
    !(up_resp.wack && up_resp.rack));

endmodule

/* adc_core.sv */
module adc_core
  import adc_core_pkg::*;
(
  input  logic        up_clk,
  input  logic        up_rstn,
  input  logic        adc_in_valid,
  input  adc_sample_t adc_data_in,
  input  logic        adc_or_in,
  input  up_req_t     up_req,
  output up_resp_t    up_resp,
  output logic        adc_valid,
  output adc_sample_t adc_data,
  output logic        adc_enable,
  output logic        adc_rst
);

  adc_word_t adc_word;
  logic      adc_status;
  up_resp_t  chan_resp;
  up_resp_t  common_resp;

  // **************************************************
  // sample path
  // **************************************************

  adc_if i_if (
    .up_clk       (up_clk),
    .up_rstn      (up_rstn),
    .adc_in_valid (adc_in_valid),
    .adc_data_in  (adc_data_in),
    .adc_or_in    (adc_or_in),
    .adc_word     (adc_word),
    .adc_status   (adc_status)
  );

  adc_channel i_channel (
    .up_clk     (up_clk),
    .up_rstn    (up_rstn),
    .adc_rst    (adc_rst),
    .adc_word   (adc_word),
    .up_req     (up_req),
    .up_resp    (chan_resp),
    .adc_valid  (adc_valid),
    .adc_data   (adc_data),
    .adc_enable (adc_enable)
  );

  adc_common i_common (
    .up_clk     (up_clk),
    .up_rstn    (up_rstn),
    .adc_status (adc_status),
    .up_req     (up_req),
    .up_resp    (common_resp),
    .adc_rst    (adc_rst)
  );

  // non-owning blocks answer with zeros, so a plain OR merges them
  always_ff @(posedge up_clk) begin
    if (!up_rstn) begin
      up_resp <= '0;
    end else begin
      up_resp.wack  <= chan_resp.wack | common_resp.wack;
      up_resp.rack  <= chan_resp.rack | common_resp.rack;
      up_resp.rdata <= chan_resp.rdata | common_resp.rdata;
    end
  end

endmodule

/* tb_clk_gen.sv */
module tb_clk_gen (
  output logic up_clk,
  output logic up_rstn
);

  timeunit 1ns;
  timeprecision 1ps;

  // 10 ns period
  initial begin
    up_clk = 1'b0;
    forever #5 up_clk = ~up_clk;
  end

  // reset held for 5 rising edges
  initial begin
    up_rstn = 1'b0;
    repeat (5) @(posedge up_clk);
    up_rstn <= 1'b1;
  end

endmodule

/* tb_adc_core.sv */
module tb_adc_core
  import adc_core_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  logic        up_clk;
  logic        up_rstn;
  logic        adc_in_valid;
  adc_sample_t adc_data_in;
  logic        adc_or_in;
  up_req_t     up_req;
  up_resp_t    up_resp;
  logic        adc_valid;
  adc_sample_t adc_data;
  logic        adc_enable;
  logic        adc_rst;

  // channel setup as the testbench last wrote it
  logic        released = 1'b0;
  logic        chan_en  = 1'b0;
  logic        chan_fmt = 1'b0;
  adc_sample_t exp_data[$];
  int          exp_due[$];
  int          cycles = 0;

  tb_clk_gen clk_gen_i (
    .up_clk  (up_clk),
    .up_rstn (up_rstn)
  );

  adc_core dut_i (
    .up_clk       (up_clk),
    .up_rstn      (up_rstn),
    .adc_in_valid (adc_in_valid),
    .adc_data_in  (adc_data_in),
    .adc_or_in    (adc_or_in),
    .up_req       (up_req),
    .up_resp      (up_resp),
    .adc_valid    (adc_valid),
    .adc_data     (adc_data),
    .adc_enable   (adc_enable),
    .adc_rst      (adc_rst)
  );

  // **************************************************
  // reference model and checks
  // **************************************************

  // x^16+x^14+x^13+x^11+1, new bit from 15, 13, 12, 10
  function automatic adc_sample_t pn_next(input adc_sample_t w);
    return {w[14:0], w[15] ^ w[13] ^ w[12] ^ w[10]};
  endfunction

  // offset binary to two's complement flips the sign bit
  function automatic adc_sample_t expect_sample(input adc_sample_t s, input logic fmt);
    return fmt ? (s ^ 16'h8000) : s;
  endfunction

  task automatic stop_on_failure();
    $display("Result: FAILED");
    $fatal(1, "run stopped on the first failure");
  endtask

  task automatic check_sample(input string name, input adc_sample_t got, input adc_sample_t exp);
    if (got !== exp) begin
      $display("ERROR at %0t ns: %s got %h, expected %h", $time, name, got, exp);
      stop_on_failure();
    end
  endtask

  task automatic check_reg(input string name, input up_data_t got, input up_data_t exp);
    if (got !== exp) begin
      $display("ERROR at %0t ns: %s got %h, expected %h", $time, name, got, exp);
      stop_on_failure();
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("ERROR at %0t ns: %s got %b, expected %b", $time, name, got, exp);
      stop_on_failure();
    end
  endtask

  // cycle count and watchdog, the tests need well under 2500 cycles
  always @(posedge up_clk) begin
    cycles <= cycles + 1;
    if (cycles == 4000) begin
      $display("timeout: the run did not finish within 4000 cycles");
      stop_on_failure();
    end
  end

  // output compare
  always @(negedge up_clk) begin
    if (up_rstn && adc_valid) begin
      if (exp_data.size() == 0) begin
        $display("adc_valid pulsed while no sample was expected");
        stop_on_failure();
      end else begin
        check_sample("adc_data", adc_data, exp_data.pop_front());
        check_reg("adc_valid cycle", up_data_t'(cycles), up_data_t'(exp_due.pop_front()));
      end
    end
  end

  // **************************************************
  // bus and sample drivers
  // **************************************************

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge up_clk);
  endtask

  task automatic bus_write(input up_addr_t addr, input up_data_t data);
    int waited;
    waited = 0;
    @(posedge up_clk);
    up_req.wreq  <= 1'b1;
    up_req.waddr <= addr;
    up_req.wdata <= data;
    @(posedge up_clk);
    up_req.wreq <= 1'b0;
    @(negedge up_clk);
    while (up_resp.wack !== 1'b1) begin
      waited++;
      if (waited > 4) begin
        $display("no write acknowledge for address %h", addr);
        stop_on_failure();
      end
      @(negedge up_clk);
    end
    check_reg("write ack latency", up_data_t'(waited + 1), 32'd2);
  endtask

  task automatic bus_read(input up_addr_t addr, output up_data_t data);
    int waited;
    waited = 0;
    @(posedge up_clk);
    up_req.rreq  <= 1'b1;
    up_req.raddr <= addr;
    @(posedge up_clk);
    up_req.rreq <= 1'b0;
    @(negedge up_clk);
    while (up_resp.rack !== 1'b1) begin
      waited++;
      if (waited > 4) begin
        $display("no read acknowledge for address %h", addr);
        stop_on_failure();
      end
      @(negedge up_clk);
    end
    check_reg("read ack latency", up_data_t'(waited + 1), 32'd2);
    data = up_resp.rdata;
  endtask

  task automatic write_cntrl(input logic en, input logic fmt);
    bus_write(ADDR_CHAN_CNTRL, {30'd0, fmt, en});
    chan_en  = en;
    chan_fmt = fmt;
    check_flag("adc_enable", adc_enable, en);
  endtask

  task automatic send_sample(input adc_sample_t data, input logic over);
    @(posedge up_clk);
    adc_in_valid <= 1'b1;
    adc_data_in  <= data;
    adc_or_in    <= over;
    if (released && chan_en) begin
      exp_data.push_back(expect_sample(data, chan_fmt));
      // counter still holds the previous edge here
      exp_due.push_back(cycles + 3);
    end
    @(posedge up_clk);
    adc_in_valid <= 1'b0;
    adc_or_in    <= 1'b0;
  endtask

  // **************************************************
  // tests
  // **************************************************

  task automatic test_registers();
    up_data_t rd;
    up_data_t wr;
    check_flag("adc_rst", adc_rst, 1'b1);
    check_flag("adc_valid", adc_valid, 1'b0);
    check_flag("adc_enable", adc_enable, 1'b0);
    check_flag("up_resp.wack", up_resp.wack, 1'b0);
    check_flag("up_resp.rack", up_resp.rack, 1'b0);
    bus_read(ADDR_VERSION, rd);
    check_reg("version", rd, CORE_VERSION);
    bus_read(ADDR_ID, rd);
    check_reg("id", rd, CORE_ID);
    repeat (8) begin
      wr = $urandom;
      bus_write(ADDR_SCRATCH, wr);
      bus_read(ADDR_SCRATCH, rd);
      check_reg("scratch", rd, wr);
    end
  endtask

  task automatic test_sample_path();
    up_data_t rd;
    bus_read(ADDR_IF_STATUS, rd);
    check_flag("if_status[0]", rd[0], 1'b0);
    // held and disabled
    repeat (3) send_sample(adc_sample_t'($urandom), 1'b0);
    wait_cycles(4);
    bus_read(ADDR_IF_STATUS, rd);
    check_flag("if_status[0]", rd[0], 1'b1);
    // enabled but still held
    write_cntrl(1'b1, 1'b0);
    repeat (3) send_sample(adc_sample_t'($urandom), 1'b0);
    wait_cycles(4);
    bus_write(ADDR_RSTN, 32'd1);
    released = 1'b1;
    check_flag("adc_rst", adc_rst, 1'b0);
    // released but disabled
    write_cntrl(1'b0, 1'b0);
    repeat (3) send_sample(adc_sample_t'($urandom), 1'b0);
    wait_cycles(4);
    write_cntrl(1'b1, 1'b0);
    repeat (8) send_sample(adc_sample_t'($urandom), 1'b0);
    write_cntrl(1'b1, 1'b1);
    bus_read(ADDR_CHAN_CNTRL, rd);
    check_reg("chan_cntrl", rd, 32'd3);
    repeat (8) send_sample(adc_sample_t'($urandom), 1'b0);
    wait_cycles(4);
  endtask

  task automatic test_pattern();
    up_data_t    rd;
    adc_sample_t last;
    last = adc_sample_t'($urandom) | 16'h0001;
    send_sample(last, 1'b0);
    repeat (6) begin
      last = pn_next(last);
      send_sample(last, 1'b0);
    end
    wait_cycles(4);
    bus_read(ADDR_CHAN_STATUS, rd);
    check_flag("chan_status pn_err", rd[0], 1'b0);
    check_flag("chan_status pn_oos", rd[1], 1'b0);
    // a single bad word keeps sync
    last = pn_next(last) ^ 16'h0001;
    send_sample(last, 1'b0);
    repeat (2) begin
      last = pn_next(last);
      send_sample(last, 1'b0);
    end
    wait_cycles(4);
    bus_read(ADDR_CHAN_STATUS, rd);
    check_flag("chan_status pn_err", rd[0], 1'b1);
    check_flag("chan_status pn_oos", rd[1], 1'b0);
    bus_write(ADDR_CHAN_STATUS, 32'd1);
    bus_read(ADDR_CHAN_STATUS, rd);
    check_flag("chan_status pn_err", rd[0], 1'b0);
    // one short of the loss count
    repeat (PN_LOSS_COUNT - 1) begin
      last = pn_next(last) ^ 16'h0001;
      send_sample(last, 1'b0);
    end
    wait_cycles(4);
    bus_read(ADDR_CHAN_STATUS, rd);
    check_flag("chan_status pn_oos", rd[1], 1'b0);
    last = pn_next(last) ^ 16'h0001;
    send_sample(last, 1'b0);
    wait_cycles(4);
    bus_read(ADDR_CHAN_STATUS, rd);
    check_flag("chan_status pn_oos", rd[1], 1'b1);
  endtask

  task automatic test_over_range();
    up_data_t rd;
    bus_read(ADDR_CHAN_STATUS, rd);
    check_flag("chan_status over_range", rd[2], 1'b0);
    send_sample(adc_sample_t'($urandom), 1'b1);
    wait_cycles(4);
    bus_read(ADDR_CHAN_STATUS, rd);
    check_flag("chan_status over_range", rd[2], 1'b1);
    send_sample(adc_sample_t'($urandom), 1'b0);
    wait_cycles(4);
    bus_read(ADDR_CHAN_STATUS, rd);
    check_flag("chan_status over_range", rd[2], 1'b1);
    // clearing bit 2 leaves the pattern error flag alone
    bus_write(ADDR_CHAN_STATUS, 32'd4);
    bus_read(ADDR_CHAN_STATUS, rd);
    check_flag("chan_status over_range", rd[2], 1'b0);
    check_flag("chan_status pn_err", rd[0], 1'b1);
  endtask

  initial begin
    void'($urandom(32'h1cf4));
    up_req       <= '0;
    adc_in_valid <= 1'b0;
    adc_data_in  <= '0;
    adc_or_in    <= 1'b0;
    wait (up_rstn === 1'b1);
    @(negedge up_clk);
    test_registers();
    test_sample_path();
    test_pattern();
    test_over_range();
    wait_cycles(6);
    if (exp_data.size() != 0) begin
      $display("%0d expected samples never came out", exp_data.size());
      stop_on_failure();
    end else begin
      $display("Result: PASSED");
      $finish;
    end
  end

endmodule

/* vlog.f */
adc_core_pkg.sv
adc_if.sv
adc_pn_mon.sv
adc_channel.sv
adc_common.sv
adc_core.sv
tb_clk_gen.sv
tb_adc_core.sv

/* Makefile */
VERILATOR  ?= verilator
FLAGS      = --binary --timing --assert -Wall -Wno-fatal --timescale 1ns/1ps
LINT_FLAGS = --lint-only --timing -Wall -Wno-fatal --timescale 1ns/1ps
TOP        = tb_adc_core
FILELIST   = vlog.f
OBJDIR     = obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)
